/* include/aexmDefines.svh */
`ifndef AEXM_DEFINES_SVH
`define AEXM_DEFINES_SVH

// Data path and address width
`define AEXM_DW 32

// General purpose registers, r0 included
`define AEXM_NREG 32

// First instruction fetched after reset
`define AEXM_RESET_PC 32'h0000_0000

`endif

/* hw/aexmPkg.sv */
package aexmPkg;

`include "aexmDefines.svh"

  typedef logic [`AEXM_DW-1:0] word_t;   // Data word or byte address
  typedef logic [4:0]          regIdx_t; // Register index
  typedef logic [15:0]         imm_t;    // Raw immediate field

  // Major opcode field, bits 31:26
  typedef enum logic [5:0] {
    OP_ADD  = 6'b000000,
    OP_RSUB = 6'b000001,
    OP_ADDI = 6'b001000,
    OP_OR   = 6'b100000,
    OP_AND  = 6'b100001,
    OP_XOR  = 6'b100010,
    OP_BRI  = 6'b101110, // Unconditional, PC relative
    OP_BEQI = 6'b101111, // Taken when rA is zero
    OP_LWI  = 6'b111010,
    OP_SWI  = 6'b111110,
    OP_NOP  = 6'b111111  // Anything unsupported
  } opcode_t;

endpackage

/* hw/aexmDecodeIf.sv */
`timescale 1ns/1ps

interface aexmDecodeIf
  import aexmPkg::*;
();

  logic    valid;    // Killed on flush
  opcode_t opcode;
  regIdx_t ra;
  regIdx_t rb;
  regIdx_t rd;       // Also store data source for SWI
  imm_t    imm;
  logic    writesRd; // Never set for r0
  logic    isLoad;

  modport decoder (
    output valid, opcode, ra, rb, rd, imm, writesRd, isLoad
  );

  modport consumer (
    input valid, opcode, ra, rb, rd, imm, writesRd, isLoad
  );

endinterface

/* hw/aexmEnable.sv */
`timescale 1ns/1ps

module aexmEnable (
  input  logic sys_clk_i,
  input  logic rst_i,
  input  logic icacheBusy_i,
  input  logic dcacheBusy_i,
  input  logic loadUseHazard_i,
  input  logic memOp_i,
  output logic cpuEnable_o,
  output logic icacheEnable_o,
  output logic dcacheEnable_o
);

  logic hazardSeen; // Stall already spent on this hazard
  logic hazardStall;

  assign hazardStall = loadUseHazard_i & ~hazardSeen;

  // Any busy cache holds the whole pipe
  assign cpuEnable_o = ~(icacheBusy_i | dcacheBusy_i | hazardStall);

  assign icacheEnable_o = cpuEnable_o;
  assign dcacheEnable_o = cpuEnable_o & memOp_i; // Only for LWI/SWI in execute

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      hazardSeen <= 1'b0;
    end else if (cpuEnable_o) begin
      hazardSeen <= 1'b0;
    end else if (hazardStall) begin
      hazardSeen <= 1'b1;
    end
  end

endmodule

/* hw/aexmIbuf.sv */
`timescale 1ns/1ps

module aexmIbuf
  import aexmPkg::*;
(
  input  logic         sys_clk_i,
  input  logic         rst_i,
  input  logic         cpuEnable_i,
  input  word_t        icacheData_i,
  input  logic         flush_i,
  input  regIdx_t      xRd_i,
  input  logic         xIsLoad_i,
  aexmDecodeIf.decoder dec,
  output logic         loadUseHazard_o
);

  word_t   instReg;
  logic    instValid;
  logic    fetchPending; // A fetch was issued on the last enabled edge
  opcode_t opc;
  logic    writesReg;
  logic    usesRa;
  logic    usesRb;
  logic    isStore;

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      fetchPending <= 1'b0;
      instValid    <= 1'b0;
    end else if (cpuEnable_i) begin
      fetchPending <= 1'b1;
      instValid    <= fetchPending & ~flush_i; // Word in flight is from the wrong path
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      instReg <= icacheData_i;
    end
  end

  always_comb begin
    case (instReg[31:26])
      OP_ADD, OP_RSUB, OP_AND, OP_OR, OP_XOR,
      OP_ADDI, OP_LWI, OP_SWI, OP_BRI, OP_BEQI: opc = opcode_t'(instReg[31:26]);
      default: opc = OP_NOP;
    endcase
  end

  always_comb begin
    writesReg = 1'b0;
    usesRa    = 1'b1;
    usesRb    = 1'b0;
    isStore   = 1'b0;
    case (opc)
      OP_ADD, OP_RSUB, OP_AND, OP_OR, OP_XOR: begin
        writesReg = 1'b1;
        usesRb    = 1'b1;
      end
      OP_ADDI, OP_LWI: writesReg = 1'b1;
      OP_SWI:          isStore   = 1'b1;
      OP_BRI, OP_NOP:  usesRa    = 1'b0;
      default: ;
    endcase
  end

  assign dec.valid    = instValid & ~flush_i;
  assign dec.opcode   = opc;
  assign dec.rd       = instReg[25:21];
  assign dec.ra       = instReg[20:16];
  assign dec.rb       = instReg[15:11];
  assign dec.imm      = instReg[15:0];
  assign dec.writesRd = writesReg & (instReg[25:21] != '0); // r0 stays zero
  assign dec.isLoad   = (opc == OP_LWI);

  // Source of the decode instruction is the load in execute
  assign loadUseHazard_o = dec.valid & xIsLoad_i & (xRd_i != '0) &
                           ((usesRa & (dec.ra == xRd_i)) |
                            (usesRb & (dec.rb == xRd_i)) |
                            (isStore & (dec.rd == xRd_i)));

endmodule

/* hw/aexmBpcu.sv */
`timescale 1ns/1ps

`include "aexmDefines.svh"

module aexmBpcu
  import aexmPkg::*;
(
  input  logic          sys_clk_i,
  input  logic          rst_i,
  input  logic          cpuEnable_i,
  input  word_t         xRegA_i,
  aexmDecodeIf.consumer dec,
  output word_t         icacheAddr_o,
  output logic          flush_o
);

  word_t fetchPc;   // Next sequential fetch
  word_t issuedPc;  // Address taken by the cache last edge
  word_t decPc;
  word_t xTarget;
  logic  xBri;
  logic  xBeqi;
  logic  taken;

  assign taken   = xBri | (xBeqi & (xRegA_i == '0));
  assign flush_o = taken;

  // Redirect goes straight onto the precycle address
  assign icacheAddr_o = taken ? xTarget : fetchPc;

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      fetchPc <= `AEXM_RESET_PC;
      xBri    <= 1'b0;
      xBeqi   <= 1'b0;
    end else if (cpuEnable_i) begin
      fetchPc <= icacheAddr_o + word_t'(4);
      xBri    <= dec.valid & (dec.opcode == OP_BRI);
      xBeqi   <= dec.valid & (dec.opcode == OP_BEQI);
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      issuedPc <= icacheAddr_o;
      decPc    <= issuedPc;
      xTarget  <= decPc + {{(`AEXM_DW-16){dec.imm[15]}}, dec.imm}; // Branch PC plus offset
    end
  end

endmodule

/* hw/aexmRegf.sv */
`timescale 1ns/1ps

`include "aexmDefines.svh"

module aexmRegf
  import aexmPkg::*;
(
  input  logic          sys_clk_i,
  input  logic          rst_i,
  input  logic          cpuEnable_i,
  aexmDecodeIf.consumer dec,
  input  regIdx_t       wbRd_i,
  input  logic          wbWe_i,
  input  logic          wbIsLoad_i,
  input  word_t         xResult_i,
  input  word_t         dcacheData_i,
  output word_t         xRegA_o,
  output word_t         xRegB_o,
  output word_t         storeData_o
);

  word_t   regs [1:`AEXM_NREG-1]; // No storage behind r0
  word_t   wbValue;
  word_t   opA;
  word_t   opB;
  word_t   opD;
  regIdx_t xRa;
  regIdx_t xRb;
  regIdx_t xRdSrc;

  assign wbValue = wbIsLoad_i ? dcacheData_i : xResult_i;

  // Register read with bypass of the value being written this cycle
  function automatic word_t readReg(regIdx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wbWe_i && (wbRd_i == idx)) begin
      return wbValue;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i && wbWe_i) begin
      regs[wbRd_i] <= wbValue;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      opA <= readReg(dec.ra);
      opB <= readReg(dec.rb);
      opD <= readReg(dec.rd);
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      xRa    <= '0;
      xRb    <= '0;
      xRdSrc <= '0;
    end else if (cpuEnable_i) begin
      xRa    <= dec.ra;
      xRb    <= dec.rb;
      xRdSrc <= dec.rd;
    end
  end

  // Result of the instruction just ahead, still in writeback
  assign xRegA_o     = (wbWe_i && (wbRd_i == xRa)) ? wbValue : opA;
  assign xRegB_o     = (wbWe_i && (wbRd_i == xRb)) ? wbValue : opB;
  assign storeData_o = (wbWe_i && (wbRd_i == xRdSrc)) ? wbValue : opD;

endmodule

/* hw/aexmXecu.sv */
`timescale 1ns/1ps

`include "aexmDefines.svh"

module aexmXecu
  import aexmPkg::*;
(
  input  logic          sys_clk_i,
  input  logic          rst_i,
  input  logic          cpuEnable_i,
  aexmDecodeIf.consumer dec,
  input  word_t         xRegA_i,
  input  word_t         xRegB_i,
  input  word_t         storeData_i,
  output word_t         xResult_o,
  output word_t         dcacheAddr_o,
  output word_t         dcacheData_o,
  output logic          dcacheWe_o,
  output logic          memOp_o,
  output regIdx_t       wbRd_o,
  output logic          wbWe_o,
  output logic          wbIsLoad_o,
  output regIdx_t       xRd_o,
  output logic          xIsLoad_o
);

  opcode_t xOpc;
  imm_t    xImm;
  regIdx_t xRd;
  logic    xWe;
  logic    xLoad;
  logic    xStore;
  word_t   immExt;
  word_t   effAddr;
  word_t   aluOut;

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      xWe    <= 1'b0;
      xLoad  <= 1'b0;
      xStore <= 1'b0;
    end else if (cpuEnable_i) begin
      xWe    <= dec.valid & dec.writesRd;
      xLoad  <= dec.valid & dec.isLoad;
      xStore <= dec.valid & (dec.opcode == OP_SWI);
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      xOpc <= dec.opcode;
      xImm <= dec.imm;
      xRd  <= dec.rd;
    end
  end

  assign immExt  = {{(`AEXM_DW-16){xImm[15]}}, xImm};
  assign effAddr = xRegA_i + immExt;

  always_comb begin
    case (xOpc)
      OP_ADD:  aluOut = xRegA_i + xRegB_i;
      OP_RSUB: aluOut = xRegB_i - xRegA_i; // rB minus rA
      OP_AND:  aluOut = xRegA_i & xRegB_i;
      OP_OR:   aluOut = xRegA_i | xRegB_i;
      OP_XOR:  aluOut = xRegA_i ^ xRegB_i;
      default: aluOut = effAddr;            // ADDI and address math
    endcase
  end

  // Precycle data cache request
  assign dcacheAddr_o = effAddr;
  assign dcacheData_o = storeData_i;
  assign dcacheWe_o   = xStore;
  assign memOp_o      = xLoad | xStore;

  assign xRd_o     = xRd;
  assign xIsLoad_o = xLoad;

  always_ff @(posedge sys_clk_i) begin
    if (rst_i) begin
      wbWe_o     <= 1'b0;
      wbIsLoad_o <= 1'b0;
    end else if (cpuEnable_i) begin
      wbWe_o     <= xWe;
      wbIsLoad_o <= xLoad;
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (cpuEnable_i) begin
      xResult_o <= aluOut;
      wbRd_o    <= xRd;
    end
  end

endmodule

/* hw/aexmEdk32.sv */
`timescale 1ns/1ps

module aexmEdk32
  import aexmPkg::*;
(
  input  logic  sys_clk_i,
  input  logic  rst_i,
  input  word_t icacheData_i,
  input  logic  icacheBusy_i,
  input  word_t dcacheData_i,
  input  logic  dcacheBusy_i,
  output word_t icacheAddr_o,
  output logic  icacheEnable_o,
  output word_t dcacheAddr_o,
  output word_t dcacheData_o,
  output logic  dcacheWe_o,
  output logic  dcacheEnable_o
);

  logic    cpuEnable;
  logic    loadUseHazard;
  logic    memOp;
  logic    flush;
  word_t   xRegA;
  word_t   xRegB;
  word_t   storeData;
  word_t   xResult;
  regIdx_t wbRd;
  logic    wbWe;
  logic    wbIsLoad;
  regIdx_t xRd;
  logic    xIsLoad;

  aexmDecodeIf decIf ();

  aexmEnable enable (
    .sys_clk_i       (sys_clk_i),
    .rst_i           (rst_i),
    .icacheBusy_i    (icacheBusy_i),
    .dcacheBusy_i    (dcacheBusy_i),
    .loadUseHazard_i (loadUseHazard),
    .memOp_i         (memOp),
    .cpuEnable_o     (cpuEnable),
    .icacheEnable_o  (icacheEnable_o),
    .dcacheEnable_o  (dcacheEnable_o)
  );

  aexmIbuf ibuf (
    .sys_clk_i       (sys_clk_i),
    .rst_i           (rst_i),
    .cpuEnable_i     (cpuEnable),
    .icacheData_i    (icacheData_i),
    .flush_i         (flush),
    .xRd_i           (xRd),
    .xIsLoad_i       (xIsLoad),
    .dec             (decIf.decoder),
    .loadUseHazard_o (loadUseHazard)
  );

  aexmBpcu bpcu (
    .sys_clk_i    (sys_clk_i),
    .rst_i        (rst_i),
    .cpuEnable_i  (cpuEnable),
    .xRegA_i      (xRegA),
    .dec          (decIf.consumer),
    .icacheAddr_o (icacheAddr_o),
    .flush_o      (flush)
  );

  aexmRegf regf (
    .sys_clk_i    (sys_clk_i),
    .rst_i        (rst_i),
    .cpuEnable_i  (cpuEnable),
    .dec          (decIf.consumer),
    .wbRd_i       (wbRd),
    .wbWe_i       (wbWe),
    .wbIsLoad_i   (wbIsLoad),
    .xResult_i    (xResult),
    .dcacheData_i (dcacheData_i),
    .xRegA_o      (xRegA),
    .xRegB_o      (xRegB),
    .storeData_o  (storeData)
  );

  aexmXecu xecu (
    .sys_clk_i    (sys_clk_i),
    .rst_i        (rst_i),
    .cpuEnable_i  (cpuEnable),
    .dec          (decIf.consumer),
    .xRegA_i      (xRegA),
    .xRegB_i      (xRegB),
    .storeData_i  (storeData),
    .xResult_o    (xResult),
    .dcacheAddr_o (dcacheAddr_o),
    .dcacheData_o (dcacheData_o),
    .dcacheWe_o   (dcacheWe_o),
    .memOp_o      (memOp),
    .wbRd_o       (wbRd),
    .wbWe_o       (wbWe),
    .wbIsLoad_o   (wbIsLoad),
    .xRd_o        (xRd),
    .xIsLoad_o    (xIsLoad)
  );

endmodule

/* tests/aexmClkGen.sv */
`timescale 1ns/1ps

module aexmClkGen #(
  parameter int periodNs    = 100,
  parameter int resetCycles = 3
) (
  output logic clk_o,
  output logic rst_o
);

  always #(periodNs / 2) clk_o = ~clk_o;

  initial begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (resetCycles) @(posedge clk_o);
    rst_o <= 1'b0; // Released on an edge like any other input
  end

endmodule

/* tests/aexmEdk32Tb.sv */
`timescale 1ns/1ps

`include "aexmDefines.svh"

module aexmEdk32Tb
  import aexmPkg::*;
();

  localparam int memWords    = 64;
  localparam int stallBudget = 40; // Cycles per instruction under random busy
  localparam int periodNs    = 100;

  logic  clk;
  logic  rst;
  word_t icacheData;
  logic  icacheBusy;
  word_t dcacheData;
  logic  dcacheBusy;
  word_t icacheAddr;
  logic  icacheEnable;
  word_t dcacheAddr;
  word_t dcacheWrData;
  logic  dcacheWe;
  logic  dcacheEnable;

  word_t imem [0:memWords-1];
  word_t dmem [0:memWords-1];
  word_t expAddr [$]; // Store sequence from the reference interpreter
  word_t expData [$];
  word_t lfsr;
  word_t haltPc;
  int    progLen;
  int    haltFetches;
  int    timeoutCycles = 0;
  int    storeChecks;
  int    valueErrors;
  int    otherErrors;
  logic  firstFetchSeen;

  aexmClkGen #(.periodNs(periodNs), .resetCycles(3)) clkGen (
    .clk_o (clk),
    .rst_o (rst)
  );

  aexmEdk32 uut (
    .sys_clk_i      (clk),
    .rst_i          (rst),
    .icacheData_i   (icacheData),
    .icacheBusy_i   (icacheBusy),
    .dcacheData_i   (dcacheData),
    .dcacheBusy_i   (dcacheBusy),
    .icacheAddr_o   (icacheAddr),
    .icacheEnable_o (icacheEnable),
    .dcacheAddr_o   (dcacheAddr),
    .dcacheData_o   (dcacheWrData),
    .dcacheWe_o     (dcacheWe),
    .dcacheEnable_o (dcacheEnable)
  );

  function automatic word_t regForm(opcode_t op, regIdx_t rd, regIdx_t ra, regIdx_t rb);
    return {op, rd, ra, rb, 11'b0};
  endfunction

  function automatic word_t immForm(opcode_t op, regIdx_t rd, regIdx_t ra, imm_t imm);
    return {op, rd, ra, imm};
  endfunction

  function automatic word_t lfsrNext(word_t s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic emit(input word_t inst);
    imem[progLen] = inst;
    progLen++;
  endtask

  task automatic loadProgram();
    int i;
    for (i = 0; i < memWords; i++) begin
      imem[i] = {OP_NOP, 26'(i)};
    end
    progLen = 0;
    // ALU chain where each result feeds the next instruction
    emit(immForm(OP_ADDI, 1, 0, 16'd5));
    emit(immForm(OP_ADDI, 2, 1, 16'd7));
    emit(regForm(OP_ADD, 3, 1, 2));
    emit(regForm(OP_RSUB, 4, 3, 2));
    emit(regForm(OP_XOR, 5, 4, 3));
    emit(regForm(OP_AND, 6, 5, 2));
    emit(regForm(OP_OR, 7, 6, 4));
    emit(immForm(OP_SWI, 3, 0, 16'h0080));
    emit(immForm(OP_SWI, 4, 0, 16'h0084));
    emit(immForm(OP_SWI, 7, 0, 16'h0088));
    emit(immForm(OP_ADDI, 8, 0, 16'h0090)); // Store base
    // Loads with an immediate user
    emit(immForm(OP_LWI, 9, 0, 16'h0010));
    emit(regForm(OP_ADD, 10, 9, 1));
    emit(immForm(OP_SWI, 10, 8, 16'd0));
    emit(immForm(OP_LWI, 11, 0, 16'h0014));
    emit(immForm(OP_SWI, 11, 8, 16'd4)); // Store data is the load result
    emit(immForm(OP_ADDI, 0, 1, 16'd99));
    emit(immForm(OP_SWI, 0, 8, 16'd8));
    // Taken BRI skips two stores
    emit(immForm(OP_BRI, 0, 0, 16'd12));
    emit(immForm(OP_SWI, 1, 8, 16'd12));
    emit(immForm(OP_SWI, 2, 8, 16'd16));
    emit(immForm(OP_ADDI, 12, 0, 16'd0));
    emit(immForm(OP_BEQI, 0, 12, 16'd12)); // Taken
    emit(immForm(OP_SWI, 1, 8, 16'd20));
    emit(immForm(OP_SWI, 1, 8, 16'd24));
    emit(immForm(OP_BEQI, 0, 1, 16'd12));  // Not taken
    emit(immForm(OP_SWI, 2, 8, 16'd28));
    emit(immForm(OP_ADDI, 13, 2, imm_t'(-3)));
    emit(immForm(OP_SWI, 13, 8, 16'd32));
    emit(immForm(OP_LWI, 14, 8, 16'd0)); // Reads back an earlier store
    emit(regForm(OP_XOR, 15, 14, 9));
    emit(immForm(OP_SWI, 15, 8, 16'd36));
    emit(immForm(OP_BRI, 0, 0, 16'd0));  // Halt loop
    haltPc = word_t'((progLen - 1) * 4);
  endtask

  task automatic preloadData();
    int    i;
    word_t addr;
    for (i = 0; i < memWords; i++) begin
      addr    = word_t'(i * 4);
      dmem[i] = addr * 32'h9e3779b1 ^ {addr[15:0], ~addr[15:0]};
    end
  endtask

  // Program order interpreter producing the expected stores
  task automatic runReference();
    word_t   regs [0:`AEXM_NREG-1];
    word_t   mem [0:memWords-1];
    word_t   pc;
    word_t   nextPc;
    word_t   inst;
    word_t   a;
    word_t   b;
    word_t   d;
    word_t   immExt;
    word_t   ea;
    word_t   res;
    logic    wr;
    logic    halted;
    regIdx_t rd;
    int      i;
    int      steps;
    for (i = 0; i < `AEXM_NREG; i++) begin
      regs[i] = '0;
    end
    for (i = 0; i < memWords; i++) begin
      mem[i] = dmem[i];
    end
    pc     = `AEXM_RESET_PC;
    halted = 1'b0;
    steps  = 0;
    while (!halted && steps < progLen * 4) begin
      inst   = imem[pc[7:2]];
      rd     = inst[25:21];
      a      = regs[inst[20:16]];
      b      = regs[inst[15:11]];
      d      = regs[rd];
      immExt = {{16{inst[15]}}, inst[15:0]};
      ea     = a + immExt;
      nextPc = pc + 4;
      wr     = 1'b1;
      res    = '0;
      case (inst[31:26])
        OP_ADD:  res = a + b;
        OP_RSUB: res = b - a;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_XOR:  res = a ^ b;
        OP_ADDI: res = ea;
        OP_LWI:  res = mem[ea[7:2]];
        OP_SWI: begin
          wr           = 1'b0;
          mem[ea[7:2]] = d;
          expAddr.push_back(ea);
          expData.push_back(d);
        end
        OP_BRI: begin
          wr     = 1'b0;
          halted = (immExt == '0);
          nextPc = pc + immExt;
        end
        OP_BEQI: begin
          wr = 1'b0;
          if (a == '0) begin
            nextPc = pc + immExt;
          end
        end
        default: wr = 1'b0; // Unsupported encodings act as NOP
      endcase
      if (wr && rd != '0) begin
        regs[rd] = res;
      end
      pc = nextPc;
      steps++;
    end
  endtask

  task automatic checkStore(input word_t addr, input word_t data);
    word_t wantAddr;
    word_t wantData;
    assert (expAddr.size() > 0) else begin
      otherErrors++;
      $display("Store of %h to %h came after the last expected store", data, addr);
    end
    if (expAddr.size() > 0) begin
      wantAddr = expAddr.pop_front();
      wantData = expData.pop_front();
      storeChecks++;
      assert (addr === wantAddr && data === wantData) else begin
        valueErrors++;
        $display("Error at %0t: store %h to %h, expected %h to %h",
                 $time, data, addr, wantData, wantAddr);
      end
    end
  endtask

  // Busy needs two set LFSR bits and comes about one cycle in four
  task automatic drawBusy(output logic busy);
    logic firstBit;
    lfsr     = lfsrNext(lfsr);
    firstBit = lfsr[0];
    lfsr     = lfsrNext(lfsr);
    busy     = firstBit & lfsr[0];
  endtask

  always @(posedge clk) begin
    logic iBusy;
    logic dBusy;
    if (rst) begin
      icacheBusy <= 1'b0;
      dcacheBusy <= 1'b0;
    end else begin
      drawBusy(iBusy);
      drawBusy(dBusy);
      icacheBusy <= iBusy;
      dcacheBusy <= dBusy;
    end
  end

  // Instruction cache model returning the addressed word on the capture edge
  always @(posedge clk) begin
    if (icacheEnable) begin
      icacheData <= imem[icacheAddr[7:2]];
      if (!rst) begin
        if (!firstFetchSeen) begin
          firstFetchSeen <= 1'b1;
          assert (icacheAddr === `AEXM_RESET_PC) else begin
            valueErrors++;
            $display("Error at %0t: first fetch from %h, expected %h",
                     $time, icacheAddr, `AEXM_RESET_PC);
          end
        end
        if (icacheAddr == haltPc) begin
          haltFetches <= haltFetches + 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (dcacheEnable && !rst) begin
      if (dcacheWe) begin
        dmem[dcacheAddr[7:2]] <= dcacheWrData;
        checkStore(dcacheAddr, dcacheWrData);
      end else begin
        dcacheData <= dmem[dcacheAddr[7:2]];
      end
    end
  end

  initial begin
    icacheData     = '0;
    icacheBusy     = 1'b0;
    dcacheData     = '0;
    dcacheBusy     = 1'b0;
    lfsr           = 32'hfde99924;
    haltFetches    = 0;
    storeChecks    = 0;
    valueErrors    = 0;
    otherErrors    = 0;
    firstFetchSeen = 1'b0;
    loadProgram();
    preloadData();
    runReference();
    timeoutCycles = progLen * stallBudget + 20;
    // Second fetch of the halt loop comes after every older store
    while (haltFetches < 2) begin
      @(posedge clk);
    end
    assert (expAddr.size() == 0) else begin
      otherErrors++;
      $display("%0d expected stores never appeared", expAddr.size());
    end
    $display("Store checks %0d, value errors %0d, other errors %0d",
             storeChecks, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (timeoutCycles > 0);
    repeat (timeoutCycles) @(posedge clk);
    $display("Timeout: the core did not reach its halt loop within %0d cycles",
             timeoutCycles);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
hw/aexmPkg.sv
hw/aexmDecodeIf.sv
hw/aexmEnable.sv
hw/aexmIbuf.sv
hw/aexmBpcu.sv
hw/aexmRegf.sv
hw/aexmXecu.sv
hw/aexmEdk32.sv
tests/aexmClkGen.sv
tests/aexmEdk32Tb.sv

/* Bender.yml */
package:
  name: aexm_edk32

export_include_dirs:
  - include

sources:
  - files:
      - hw/aexmPkg.sv
      - hw/aexmDecodeIf.sv
      - hw/aexmEnable.sv
      - hw/aexmIbuf.sv
      - hw/aexmBpcu.sv
      - hw/aexmRegf.sv
      - hw/aexmXecu.sv
      - hw/aexmEdk32.sv
  - target: test
    files:
      - tests/aexmClkGen.sv
      - tests/aexmEdk32Tb.sv
